// File: verilog/aes_pkg.sv
// AES-128 word and block types, round limit, selector enums, word select and round constants
package aes_pkg;

	// One state column or one key word, row 0 in the top byte
	typedef logic [31:0] aes_word_t;
	// Column 0 sits in bits 127:96
	typedef logic [127:0] aes_block_t;
	typedef logic [3:0] round_t;

	localparam round_t num_rounds = 4'd10;

	// Column 0..3 of the state, or word 3 of the key for the G function
	typedef enum logic [2:0]
	{
		SBOX_COL0,
		SBOX_COL1,
		SBOX_COL2,
		SBOX_COL3,
		SBOX_G
	} sbox_sel_t;

	// Source of a state column write
	typedef enum logic [1:0]
	{
		COL_SHIFT_ROWS,
		COL_ADD_RK,
		COL_INPUT
	} col_sel_t;

	// Word i of a block, counted from the most significant end
	function automatic aes_word_t blk_word(aes_block_t b, logic [1:0] i);
		return b[32 * (3 - i) +: 32];
	endfunction

	// Round constant byte of rounds 1 to 10
	function automatic logic [7:0] rcon(round_t r);
		case (r)
			4'd1: return 8'h01;
			4'd2: return 8'h02;
			4'd3: return 8'h04;
			4'd4: return 8'h08;
			4'd5: return 8'h10;
			4'd6: return 8'h20;
			4'd7: return 8'h40;
			4'd8: return 8'h80;
			4'd9: return 8'h1b;
			4'd10: return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

// File: verilog/host_pkg.sv
// Wishbone request and response structs, register map, chaining modes and host configuration
package host_pkg;

	// Master to slave, held until ack
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr;
		logic [31:0] dat;
	} wb_req_t;

	// Slave to master, data valid with ack
	typedef struct packed
	{
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [1:0]
	{
		MODE_ECB = 2'd0,
		MODE_CBC = 2'd1,
		MODE_CTR = 2'd2
	} chain_mode_t;

	// ====================
	// Word addresses
	// ====================
	// KEYR0 and IVR0 carry the most significant word
	typedef enum logic [3:0]
	{
		REG_CR = 4'd0,
		REG_SR = 4'd1,
		REG_DINR = 4'd2,
		REG_DOUTR = 4'd3,
		REG_KEYR0 = 4'd4,
		REG_KEYR1 = 4'd5,
		REG_KEYR2 = 4'd6,
		REG_KEYR3 = 4'd7,
		REG_IVR0 = 4'd8,
		REG_IVR1 = 4'd9,
		REG_IVR2 = 4'd10,
		REG_IVR3 = 4'd11
	} reg_addr_t;

	// Settings seen by the core
	typedef struct packed
	{
		logic enable;
		chain_mode_t mode;
		aes_pkg::aes_block_t key;
		aes_pkg::aes_block_t iv;
		// One cycle pulse after an IVR3 write
		logic iv_load;
	} host_cfg_t;

endpackage

// File: verilog/aes_sbox.sv
// Forward SubBytes on one 32-bit word, four lookups into one shared table
module aes_sbox
(
	input aes_pkg::aes_word_t in_word,
	output aes_pkg::aes_word_t out_word
);

	// ====================
	// Forward S-box
	// ====================
	// Entry 0 is the leftmost byte
	localparam logic [0:255][7:0] sbox_tab =
	{
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Bytewise, so row order is kept
	always_comb
	begin
		for (int b = 0; b < 4; b++)
		begin
			out_word[8 * b +: 8] = sbox_tab[in_word[8 * b +: 8]];
		end
	end

endmodule

// File: verilog/aes_control_unit.sv
// Round sequencing FSM, round counter and datapath and key schedule selects
module aes_control_unit
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic abort,
	input host_pkg::chain_mode_t mode,
	output logic busy,
	output logic done,
	output aes_pkg::sbox_sel_t sbox_sel,
	output aes_pkg::col_sel_t col_sel,
	output logic [3:0] col_en,
	output logic [3:0] key_en,
	output logic key_sel,
	output logic bypass_rk,
	output logic last_round,
	output logic iv_cnt_en,
	output aes_pkg::round_t round
);
	import aes_pkg::*;
	import host_pkg::*;

	typedef enum logic [3:0]
	{
		IDLE,
		ROUND0_COL0,
		ROUND0_COL1,
		ROUND0_COL2,
		ROUND0_COL3,
		ROUND_KEY,
		ROUND_COL0,
		ROUND_COL1,
		ROUND_COL2,
		ROUND_COL3,
		READY
	} state_t;

	state_t state;
	state_t next_state;
	round_t rd_count;
	logic rd_count_en;
	logic mode_ctr;
	logic [1:0] col_idx;

	assign mode_ctr = (mode == MODE_CTR);
	assign busy = (state != IDLE);
	assign done = (state == READY);
	assign round = rd_count;
	assign last_round = (rd_count == num_rounds);

	// ====================
	// State register
	// ====================
	// Abort from the host wins over any step
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (abort)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Forward walk only, key cycle between rounds
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (start)
					next_state = ROUND0_COL0;
			end
			ROUND0_COL0: next_state = ROUND0_COL1;
			ROUND0_COL1: next_state = ROUND0_COL2;
			ROUND0_COL2: next_state = ROUND0_COL3;
			ROUND0_COL3: next_state = ROUND_KEY;
			ROUND_KEY: next_state = ROUND_COL0;
			ROUND_COL0: next_state = ROUND_COL1;
			ROUND_COL1: next_state = ROUND_COL2;
			ROUND_COL2: next_state = ROUND_COL3;
			// Round 10 skips its key cycle
			ROUND_COL3: next_state = last_round ? READY : ROUND_KEY;
			READY: next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	// Column handled in the current cycle
	always_comb
	begin
		case (state)
			ROUND0_COL1, ROUND_COL1: col_idx = 2'd1;
			ROUND0_COL2, ROUND_COL2: col_idx = 2'd2;
			ROUND0_COL3, ROUND_COL3: col_idx = 2'd3;
			default: col_idx = 2'd0;
		endcase
	end

	// ====================
	// Output decode
	// ====================
	always_comb
	begin
		sbox_sel = SBOX_COL0;
		col_sel = COL_ADD_RK;
		col_en = 4'b0000;
		key_en = 4'b0000;
		key_sel = 1'b1;
		bypass_rk = 1'b0;
		iv_cnt_en = 1'b0;
		rd_count_en = 1'b0;
		case (state)
			IDLE:
			begin
				// Fresh key from the host for every block
				if (start)
				begin
					key_sel = 1'b0;
					key_en = 4'b1111;
				end
			end
			ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
			begin
				// Input word XOR key word, no MixColumns
				sbox_sel = sbox_sel_t'({1'b0, col_idx});
				bypass_rk = 1'b1;
				if (col_idx == 2'd3)
				begin
					col_sel = COL_SHIFT_ROWS;
					col_en = 4'b1111;
				end
				else
					col_en = 4'b0001 << col_idx;
			end
			ROUND_KEY:
			begin
				// S-box serves the G function on key word 3
				sbox_sel = SBOX_G;
				key_en = 4'b0001;
				rd_count_en = 1'b1;
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				sbox_sel = sbox_sel_t'({1'b0, col_idx});
				// Next key word follows one column behind
				if (col_idx != 2'd3)
					key_en = 4'b0010 << col_idx;
				if (last_round)
				begin
					// Keystream XOR input data in CTR
					col_sel = mode_ctr ? COL_INPUT : COL_ADD_RK;
					col_en = 4'b0001 << col_idx;
					iv_cnt_en = mode_ctr && (col_idx == 2'd3);
				end
				else if (col_idx == 2'd3)
				begin
					col_sel = COL_SHIFT_ROWS;
					col_en = 4'b1111;
				end
				else
					col_en = 4'b0001 << col_idx;
			end
			default:
			begin
				col_en = 4'b0000;
			end
		endcase
	end

	// Round counter, cleared whenever idle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rd_count <= '0;
		else if (state == IDLE)
			rd_count <= '0;
		else if (rd_count_en)
			rd_count <= rd_count + 4'd1;
	end

	// Single column write, or the whole state on ShiftRows
	assert property (@(posedge clk) disable iff (!rst_n)
		(col_en != 4'b0000) |-> ($onehot(col_en) || (col_en == 4'b1111)));

	// All ten key cycles were taken before done
	assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (rd_count == num_rounds));

endmodule

// File: verilog/aes_key_schedule.sv
// Round key word registers and on-the-fly next round key computation
module aes_key_schedule
(
	input logic clk,
	input logic rst_n,
	input aes_pkg::aes_block_t key_host,
	input logic key_sel,
	input logic [3:0] key_en,
	input aes_pkg::round_t round,
	input aes_pkg::aes_word_t sub_word,
	output aes_pkg::aes_block_t rk
);
	import aes_pkg::*;

	// Current round key, word 0 first
	aes_word_t w [4];
	aes_word_t w_next [4];
	aes_word_t g_word;

	// Counter still holds the finished round in the key cycle
	// RotWord after SubWord, same result as before since both are bytewise
	assign g_word = {sub_word[23:0], sub_word[31:24]} ^
		{rcon(round_t'(round + 4'd1)), 24'h000000};

	// ====================
	// Next key words
	// ====================
	always_comb
	begin
		w_next[0] = w[0] ^ g_word;
		// Previous word is already updated one cycle earlier
		for (int i = 1; i < 4; i++)
		begin
			w_next[i] = w[i] ^ w[i - 1];
		end
	end

	// Host load on start, otherwise one word per enabled cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 4; i++)
			begin
				w[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (key_en[i])
					w[i] <= key_sel ? w_next[i] : blk_word(key_host, 2'(i));
			end
		end
	end

	assign rk = {w[0], w[1], w[2], w[3]};

endmodule

// File: verilog/aes_datapath.sv
// State columns, MixColumns, AddRoundKey, ShiftRows, chaining register and counter
module aes_datapath
(
	input logic clk,
	input logic rst_n,
	input aes_pkg::aes_block_t din,
	input aes_pkg::aes_block_t iv,
	input logic iv_load,
	input host_pkg::chain_mode_t mode,
	input aes_pkg::sbox_sel_t sbox_sel,
	input aes_pkg::col_sel_t col_sel,
	input logic [3:0] col_en,
	input logic bypass_rk,
	input logic last_round,
	input logic iv_cnt_en,
	input aes_pkg::aes_block_t rk,
	output aes_pkg::aes_word_t sub_word,
	output aes_pkg::aes_block_t dout
);
	import aes_pkg::*;
	import host_pkg::*;

	aes_word_t col [4];
	// CBC chaining value, or CTR counter block
	aes_block_t chain;
	aes_block_t blk_in;
	aes_block_t pre_sr;
	aes_block_t sr_blk;
	aes_word_t sel_col;
	aes_word_t mix_out;
	aes_word_t ark_in;
	aes_word_t ark;
	aes_word_t sbox_in;
	aes_word_t res_word;
	logic [1:0] idx;
	logic cbc_update;

	function automatic logic [7:0] xtime(logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Matrix 2 3 1 1 on one column
	function automatic aes_word_t mix_column(aes_word_t w);
		logic [7:0] a0, a1, a2, a3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// Row r rotates left by r columns
	function automatic aes_block_t shift_rows(aes_block_t s);
		aes_block_t r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
			begin
				r[32 * (3 - c) + 8 * (3 - row) +: 8] =
					s[32 * (3 - ((c + row) % 4)) + 8 * (3 - row) +: 8];
			end
		end
		return r;
	endfunction

	// ====================
	// Cipher input
	// ====================
	always_comb
	begin
		case (mode)
			MODE_CBC: blk_in = din ^ chain;
			MODE_CTR: blk_in = chain;
			default: blk_in = din;
		endcase
	end

	assign idx = sbox_sel[1:0];
	assign sel_col = col[idx];
	assign mix_out = mix_column(sel_col);

	// Round 0 takes the input word, last round has no MixColumns
	always_comb
	begin
		if (bypass_rk)
			ark_in = blk_word(blk_in, idx);
		else if (last_round)
			ark_in = sel_col;
		else
			ark_in = mix_out;
	end

	assign ark = ark_in ^ blk_word(rk, idx);
	assign sbox_in = (sbox_sel == SBOX_G) ? blk_word(rk, 2'd3) : ark;
	// Final round result is stored before SubBytes
	assign res_word = last_round ? ark : sub_word;

	aes_sbox aes_sbox_i
	(
		.in_word(sbox_in),
		.out_word(sub_word)
	);

	// ShiftRows sees the current column already substituted
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			pre_sr[32 * (3 - i) +: 32] = (2'(i) == idx) ? res_word : col[i];
		end
	end

	assign sr_blk = shift_rows(pre_sr);

	// ====================
	// State columns
	// ====================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 4; i++)
			begin
				col[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (col_en[i])
				begin
					case (col_sel)
						COL_SHIFT_ROWS: col[i] <= blk_word(sr_blk, 2'(i));
						COL_ADD_RK: col[i] <= res_word;
						COL_INPUT: col[i] <= ark ^ blk_word(din, idx);
						default: col[i] <= col[i];
					endcase
				end
			end
		end
	end

	// Ciphertext becomes the next IV
	assign cbc_update = (mode == MODE_CBC) && last_round && col_en[3];

	always_ff @(posedge clk)
	begin
		if (iv_load)
			chain <= iv;
		else if (iv_cnt_en)
			chain <= chain + 128'd1;
		else if (cbc_update)
			chain <= {col[0], col[1], col[2], res_word};
	end

	assign dout = {col[0], col[1], col[2], col[3]};

endmodule

// File: verilog/aes_host_if.sv
// Wishbone classic slave with control, status, data, key and IV registers
module aes_host_if
(
	input logic clk,
	input logic rst_n,
	input host_pkg::wb_req_t wb_req,
	output host_pkg::wb_rsp_t wb_rsp,
	output host_pkg::host_cfg_t cfg,
	output aes_pkg::aes_block_t din,
	output logic start,
	output logic abort,
	input aes_pkg::aes_block_t dout,
	input logic done,
	input logic busy
);
	import aes_pkg::*;
	import host_pkg::*;

	logic ack_q;
	aes_word_t rdata_q;
	aes_word_t rd_mux;
	logic enable_q;
	chain_mode_t mode_q;
	logic iv_load_q;
	aes_block_t key_q;
	aes_block_t iv_q;
	aes_block_t din_q;
	logic [1:0] din_ptr;
	logic [1:0] dout_ptr;
	logic ccf;
	logic wrerr;
	logic access;
	logic wr_acc;
	logic rd_acc;
	logic blocked;
	reg_addr_t addr;

	// New access only while ack is low
	assign access = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_acc = access && wb_req.we;
	assign rd_acc = access && !wb_req.we;
	assign addr = reg_addr_t'(wb_req.adr);
	// Start cycle counts as busy too
	assign blocked = busy || start;

	// ====================
	// Read mux
	// ====================
	always_comb
	begin
		case (addr)
			REG_CR: rd_mux = {29'd0, mode_q, enable_q};
			REG_SR: rd_mux = {29'd0, wrerr, busy, ccf};
			REG_DOUTR: rd_mux = blk_word(dout, dout_ptr);
			REG_KEYR0, REG_KEYR1, REG_KEYR2, REG_KEYR3: rd_mux = blk_word(key_q, wb_req.adr[1:0]);
			REG_IVR0, REG_IVR1, REG_IVR2, REG_IVR3: rd_mux = blk_word(iv_q, wb_req.adr[1:0]);
			default: rd_mux = '0;
		endcase
	end

	// Control, pointers and flags
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ack_q <= 1'b0;
			enable_q <= 1'b0;
			mode_q <= MODE_ECB;
			iv_load_q <= 1'b0;
			din_ptr <= '0;
			dout_ptr <= '0;
			ccf <= 1'b0;
			wrerr <= 1'b0;
			start <= 1'b0;
			abort <= 1'b0;
		end
		else
		begin
			ack_q <= access;
			start <= 1'b0;
			abort <= 1'b0;
			iv_load_q <= 1'b0;
			if (done)
				ccf <= 1'b1;
			if (wr_acc && addr == REG_CR)
			begin
				enable_q <= wb_req.dat[0];
				mode_q <= chain_mode_t'(wb_req.dat[2:1]);
				wrerr <= 1'b0;
				// Disable stops the core and rewinds both pointers
				if (!wb_req.dat[0])
				begin
					abort <= 1'b1;
					din_ptr <= '0;
					dout_ptr <= '0;
				end
			end
			if (wr_acc && addr == REG_DINR)
			begin
				if (blocked)
					wrerr <= 1'b1;
				else
				begin
					din_ptr <= din_ptr + 2'd1;
					// Fourth word kicks off the block
					start <= enable_q && (din_ptr == 2'd3);
				end
			end
			if (wr_acc && addr == REG_IVR3)
				iv_load_q <= 1'b1;
			if (rd_acc && addr == REG_DOUTR)
			begin
				dout_ptr <= dout_ptr + 2'd1;
				if (dout_ptr == 2'd3)
					ccf <= 1'b0;
			end
		end
	end

	// ====================
	// Data registers
	// ====================
	always_ff @(posedge clk)
	begin
		if (rd_acc)
			rdata_q <= rd_mux;
		if (wr_acc && addr == REG_DINR && !blocked)
			din_q[32 * (3 - din_ptr) +: 32] <= wb_req.dat;
		if (wr_acc && wb_req.adr[3:2] == 2'b01)
			key_q[32 * (3 - wb_req.adr[1:0]) +: 32] <= wb_req.dat;
		if (wr_acc && wb_req.adr[3:2] == 2'b10)
			iv_q[32 * (3 - wb_req.adr[1:0]) +: 32] <= wb_req.dat;
	end

	assign wb_rsp = '{ack: ack_q, dat: rdata_q};
	assign cfg = '{enable: enable_q, mode: mode_q, key: key_q, iv: iv_q, iv_load: iv_load_q};
	assign din = din_q;

	// Single cycle ack per access
	assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack);

endmodule

// File: verilog/aes_core_top.sv
// AES-128 core top level with host interface, control unit, key schedule and datapath
module aes_core_top
(
	input logic clk,
	input logic rst_n,
	input host_pkg::wb_req_t wb_req,
	output host_pkg::wb_rsp_t wb_rsp
);
	import aes_pkg::*;
	import host_pkg::*;

	host_cfg_t cfg;
	aes_block_t din;
	aes_block_t dout;
	aes_block_t rk;
	aes_word_t sub_word;
	logic start;
	logic abort;
	logic busy;
	logic done;
	sbox_sel_t sbox_sel;
	col_sel_t col_sel;
	logic [3:0] col_en;
	logic [3:0] key_en;
	logic key_sel;
	logic bypass_rk;
	logic last_round;
	logic iv_cnt_en;
	round_t round;

	// ====================
	// Bus side
	// ====================
	aes_host_if aes_host_if_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.cfg(cfg),
		.din(din),
		.start(start),
		.abort(abort),
		.dout(dout),
		.done(done),
		.busy(busy)
	);

	// Sequencer
	aes_control_unit aes_control_unit_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.abort(abort),
		.mode(cfg.mode),
		.busy(busy),
		.done(done),
		.sbox_sel(sbox_sel),
		.col_sel(col_sel),
		.col_en(col_en),
		.key_en(key_en),
		.key_sel(key_sel),
		.bypass_rk(bypass_rk),
		.last_round(last_round),
		.iv_cnt_en(iv_cnt_en),
		.round(round)
	);

	// ====================
	// Cipher side
	// ====================
	aes_key_schedule aes_key_schedule_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.key_host(cfg.key),
		.key_sel(key_sel),
		.key_en(key_en),
		.round(round),
		.sub_word(sub_word),
		.rk(rk)
	);

	// S-box lives in here, shared with the key G function
	aes_datapath aes_datapath_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.din(din),
		.iv(cfg.iv),
		.iv_load(cfg.iv_load),
		.mode(cfg.mode),
		.sbox_sel(sbox_sel),
		.col_sel(col_sel),
		.col_en(col_en),
		.bypass_rk(bypass_rk),
		.last_round(last_round),
		.iv_cnt_en(iv_cnt_en),
		.rk(rk),
		.sub_word(sub_word),
		.dout(dout)
	);

endmodule

// File: bench/aes_core_tb.sv
// AES-128 core testbench with Wishbone tasks, FIPS-197 and SP 800-38A directed tests and watchdog
module aes_core_tb;
	import aes_pkg::*;
	import host_pkg::*;

	localparam int clk_period = 20;
	localparam int num_tests = 5;
	localparam int ack_limit = 16;
	localparam int poll_limit = 100;
	// Longest bus cycle, idle gap, request edge, ack wait and release edge
	localparam int bus_cycles_max = 3 + 1 + ack_limit + 2;
	// Status polling of one block with every poll running to its limit
	localparam int poll_cycles = (poll_limit + 1) * bus_cycles_max;

	// ====================
	// Reference vectors
	// ====================
	// FIPS-197 appendix C.1
	localparam aes_block_t fips_key = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_block_t fips_pt = 128'h00112233445566778899aabbccddeeff;
	localparam aes_block_t fips_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	// SP 800-38A F.1, F.2 and F.5, first two blocks
	localparam aes_block_t nist_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_block_t nist_p1 = 128'h6bc1bee22e409f96e93d7e117393172a;
	localparam aes_block_t nist_p2 = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
	localparam aes_block_t ecb_c1 = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
	localparam aes_block_t ecb_c2 = 128'hf5d3d58503b9699de785895a96fdbaaf;
	localparam aes_block_t cbc_iv = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_block_t cbc_c1 = 128'h7649abac8119b246cee98e9b12e9197d;
	localparam aes_block_t cbc_c2 = 128'h5086cb9b507219ee95db113a917678b2;
	localparam aes_block_t ctr_iv = 128'hf0f1f2f3f4f5f6f7f8f9fafbfcfdfeff;
	localparam aes_block_t ctr_c1 = 128'h874d6191b620e3261bef6864990db6ce;
	localparam aes_block_t ctr_c2 = 128'h9806f66b7970fdff8617187bb9fffdff;

	logic clk;
	logic rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [31:0] lcg_state;
	int error_count;
	int check_count;

	aes_core_top aes_core_top_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	// Numerical Recipes LCG constants
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Zero to three idle cycles
	task automatic idle_gap();
		logic [31:0] r;
		r = next_random();
		repeat (r[31:30]) @(posedge clk);
	endtask

	// ====================
	// Bus tasks
	// ====================
	// One classic cycle, request held until ack, ack sampled mid-cycle
	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		idle_gap();
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		waited = 0;
		@(negedge clk);
		while (!wb_rsp.ack && waited < ack_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (!wb_rsp.ack)
		begin
			error_count++;
			$display("No Wishbone ack within %0d cycles for address %h", ack_limit, adr);
		end
		rdat = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'h0, dat);
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_block(input string name, input aes_block_t got,
		input aes_block_t expected);
		for (int i = 0; i < 4; i++)
		begin
			check_word($sformatf("%s[%0d]", name, i), got[32 * (3 - i) +: 32],
				expected[32 * (3 - i) +: 32]);
		end
	endtask

	// Word 0 is the most significant
	task automatic load_key(input aes_block_t key);
		for (int i = 0; i < 4; i++)
		begin
			wb_write(4'(REG_KEYR0 + i), key[32 * (3 - i) +: 32]);
		end
	endtask

	// IVR3 last, it triggers the chaining register load
	task automatic load_iv(input aes_block_t iv);
		for (int i = 0; i < 4; i++)
		begin
			wb_write(4'(REG_IVR0 + i), iv[32 * (3 - i) +: 32]);
		end
	endtask

	task automatic enable_core(input chain_mode_t m);
		wb_write(REG_CR, {29'd0, m, 1'b1});
	endtask

	task automatic write_block(input aes_block_t blk);
		for (int i = 0; i < 4; i++)
		begin
			wb_write(REG_DINR, blk[32 * (3 - i) +: 32]);
		end
	endtask

	task automatic read_block(output aes_block_t blk);
		logic [31:0] w;
		for (int i = 0; i < 4; i++)
		begin
			wb_read(REG_DOUTR, w);
			blk[32 * (3 - i) +: 32] = w;
		end
	endtask

	// Poll SR until ccf, bounded
	task automatic wait_ccf(output logic [31:0] sr);
		int polls;
		polls = 0;
		wb_read(REG_SR, sr);
		while (!sr[0] && polls < poll_limit)
		begin
			wb_read(REG_SR, sr);
			polls++;
		end
		if (!sr[0])
		begin
			error_count++;
			$display("Computation complete flag never set after %0d status polls", poll_limit);
		end
	endtask

	task automatic run_block(input aes_block_t blk, output aes_block_t res);
		logic [31:0] sr;
		write_block(blk);
		wait_ccf(sr);
		read_block(res);
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic fips_known_answer();
		aes_block_t ct;
		logic [31:0] sr;
		// Nothing pending out of reset
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h0);
		load_key(fips_key);
		enable_core(MODE_ECB);
		run_block(fips_pt, ct);
		check_block("DOUTR", ct, fips_ct);
	endtask

	// Second block only right if the key is reloaded
	task automatic ecb_two_blocks();
		aes_block_t ct;
		load_key(nist_key);
		enable_core(MODE_ECB);
		run_block(nist_p1, ct);
		check_block("DOUTR", ct, ecb_c1);
		run_block(nist_p2, ct);
		check_block("DOUTR", ct, ecb_c2);
	endtask

	// No IV rewrite between the blocks
	task automatic cbc_chaining();
		aes_block_t ct;
		load_key(nist_key);
		enable_core(MODE_CBC);
		load_iv(cbc_iv);
		run_block(nist_p1, ct);
		check_block("DOUTR", ct, cbc_c1);
		run_block(nist_p2, ct);
		check_block("DOUTR", ct, cbc_c2);
	endtask

	// Counter steps by one per block
	task automatic ctr_counter();
		aes_block_t ct;
		load_key(nist_key);
		enable_core(MODE_CTR);
		load_iv(ctr_iv);
		run_block(nist_p1, ct);
		check_block("DOUTR", ct, ctr_c1);
		run_block(nist_p2, ct);
		check_block("DOUTR", ct, ctr_c2);
	endtask

	task automatic register_behavior();
		aes_block_t rnd_key;
		aes_block_t rnd_iv;
		aes_block_t ct;
		logic [31:0] rd;
		logic [31:0] sr;
		// Key and IV readback
		for (int i = 0; i < 4; i++)
		begin
			rnd_key[32 * (3 - i) +: 32] = next_random();
			rnd_iv[32 * (3 - i) +: 32] = next_random();
		end
		load_key(rnd_key);
		load_iv(rnd_iv);
		for (int i = 0; i < 4; i++)
		begin
			wb_read(4'(REG_KEYR0 + i), rd);
			check_word($sformatf("KEYR%0d", i), rd, rnd_key[32 * (3 - i) +: 32]);
			wb_read(4'(REG_IVR0 + i), rd);
			check_word($sformatf("IVR%0d", i), rd, rnd_iv[32 * (3 - i) +: 32]);
		end
		// Busy after start, extra word sets wrerr
		load_key(fips_key);
		enable_core(MODE_ECB);
		write_block(fips_pt);
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h2);
		wb_write(REG_DINR, 32'hdead_beef);
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h6);
		// Ignored word must not disturb the result
		wait_ccf(sr);
		check_word("SR", sr, 32'h5);
		read_block(ct);
		check_block("DOUTR", ct, fips_ct);
		// ccf gone after four reads, wrerr kept until CR write
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h4);
		// Disable mid-block
		enable_core(MODE_ECB);
		write_block(fips_pt);
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h2);
		wb_write(REG_CR, 32'h0);
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h0);
		// Past the point where the block would have ended
		repeat (80) @(posedge clk);
		wb_read(REG_SR, sr);
		check_word("SR", sr, 32'h0);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial
	begin
		wb_req <= '0;
		rst_n <= 1'b0;
		lcg_state = 32'hd2ba_6397;
		error_count = 0;
		check_count = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		fips_known_answer();
		ecb_two_blocks();
		cbc_chaining();
		ctr_counter();
		register_behavior();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(num_tests * poll_cycles * clk_period);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		$display("Something failed");
		$finish;
	end

endmodule

// File: compile.f
verilog/aes_pkg.sv
verilog/host_pkg.sv
verilog/aes_sbox.sv
verilog/aes_control_unit.sv
verilog/aes_key_schedule.sv
verilog/aes_datapath.sv
verilog/aes_host_if.sv
verilog/aes_core_top.sv
bench/aes_core_tb.sv

// File: Makefile
SIM = verilator
SIM_FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP = aes_core_tb
FILE_LIST = compile.f
OBJ_DIR = obj_dir
PASS_MSG = Everything OK

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
